//--- all.f
cpu_pkg.sv
program_counter.sv
control_sequencer.sv
alu.sv
datapath_registers.sv
input_mar_register.sv
dff_mem.sv
cpu_top.sv
tb_checker.sv
tb_cpu.sv

//--- alu.sv
// 8-bit add/sub; carry on sub means no borrow, flags only update when the result is driven
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hold,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  logic [7:0]          reg_a,
    input  logic [7:0]          reg_b,
    output logic [7:0]          alu_out,
    output logic                cf,
    output logic                zf
);
    logic [8:0] result;

    // a - b as a + ~b + 1, so bit 8 is the no-borrow carry
    assign result = {1'b0, reg_a} + {1'b0, reg_b ^ {8{ctrl.sub}}} + {8'd0, ctrl.sub};

    assign alu_out = result[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (hold) begin
            // fresh flags for each loaded program
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (ctrl.eu) begin
            cf <= result[8];
            zf <= (result[7:0] == 8'd0);
        end
    end

endmodule

`default_nettype wire

//--- control_sequencer.sv
// fixed 6-cycle microcode; idle word while held or halted, halt only cleared by reset or hold
`timescale 1ns/10ps
`default_nettype none

module control_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hold,
    input  cpu_pkg::opcode_t    opcode,
    input  logic                cf,
    input  logic                zf,
    output cpu_pkg::ctrl_word_t ctrl,
    output logic                halted
);
    import cpu_pkg::*;

    localparam logic [2:0] T_LAST = 3'(T_STATES - 1);

    logic [2:0] t_state;
    logic       halt_now;

    // hlt takes effect at the end of its first execute cycle
    assign halt_now = (t_state == T3) && (opcode == HLT) && !halted;

    // t-state ring
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t_state <= T0;
            halted  <= 1'b0;
        end else if (hold) begin
            t_state <= T0;
            halted  <= 1'b0;
        end else if (halt_now) begin
            // freeze at T3 for good
            halted <= 1'b1;
        end else if (!halted) begin
            t_state <= (t_state == T_LAST) ? T0 : t_state + 3'd1;
        end
    end

    // microcode table
    always_comb begin
        ctrl = CTRL_IDLE;
        if (!hold && !halted) begin
            case (t_state)
                T0: begin
                    // pc -> mar
                    ctrl.ep    = 1'b1;
                    ctrl.n_lma = 1'b0;
                end
                T1: begin
                    // mem -> ir, pc + 1
                    ctrl.n_ce = 1'b0;
                    ctrl.n_li = 1'b0;
                    ctrl.cp   = 1'b1;
                end
                T3: begin
                    case (opcode)
                        LDA, ADD, SUB, STA: begin
                            // operand -> mar
                            ctrl.n_ei  = 1'b0;
                            ctrl.n_lma = 1'b0;
                        end
                        LDI: begin
                            ctrl.n_ei = 1'b0;
                            ctrl.n_la = 1'b0;
                        end
                        JMP: begin
                            ctrl.n_ei = 1'b0;
                            ctrl.lp   = 1'b1;
                        end
                        JC: begin
                            // not taken leaves the incremented pc alone
                            ctrl.n_ei = !cf;
                            ctrl.lp   = cf;
                        end
                        JZ: begin
                            ctrl.n_ei = !zf;
                            ctrl.lp   = zf;
                        end
                        OUT: begin
                            ctrl.ea   = 1'b1;
                            ctrl.n_lo = 1'b0;
                        end
                        default: ;
                    endcase
                end
                T4: begin
                    case (opcode)
                        LDA: begin
                            ctrl.n_ce = 1'b0;
                            ctrl.n_la = 1'b0;
                        end
                        ADD, SUB: begin
                            ctrl.n_ce = 1'b0;
                            ctrl.n_lb = 1'b0;
                        end
                        STA: begin
                            // a -> mar data register
                            ctrl.ea    = 1'b1;
                            ctrl.n_lmd = 1'b0;
                        end
                        default: ;
                    endcase
                end
                T5: begin
                    case (opcode)
                        ADD, SUB: begin
                            // alu result back to a, flags latch
                            ctrl.eu   = 1'b1;
                            ctrl.sub  = (opcode == SUB);
                            ctrl.n_la = 1'b0;
                        end
                        STA: begin
                            ctrl.n_lr = 1'b0;
                        end
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    // at most one bus source per cycle across the whole table
    a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
        $countones({ctrl.ep, !ctrl.n_ce, !ctrl.n_ei, ctrl.ea, ctrl.eu}) <= 1);

    // halt is sticky until the pins reload the machine
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted && !hold |=> halted);

endmodule

`default_nettype wire

//--- cpu_pkg.sv
// shared types for the 16-byte accumulator cpu; control bit order and opcode values are fixed
`default_nettype none

package cpu_pkg;

    // memory address width, one nibble of the instruction word
    localparam int ADDR_W = 4;

    // every instruction takes the same number of cycles
    localparam int T_STATES = 6;

    // t-state encodings used by the sequencer
    localparam logic [2:0] T0 = 3'd0;
    localparam logic [2:0] T1 = 3'd1;
    localparam logic [2:0] T2 = 3'd2;
    localparam logic [2:0] T3 = 3'd3;
    localparam logic [2:0] T4 = 3'd4;
    localparam logic [2:0] T5 = 3'd5;

    // codes not listed decode as no-op
    typedef enum logic [3:0] {
        LDA = 4'd0,
        ADD = 4'd1,
        SUB = 4'd2,
        STA = 4'd3,
        LDI = 4'd4,
        JMP = 4'd5,
        JC  = 4'd6,
        JZ  = 4'd7,
        OUT = 4'd14,
        HLT = 4'd15
    } opcode_t;

    // 15-bit control word, cp is the msb
    // n_* strobes are active low, the rest active high
    typedef struct packed {
        logic cp;
        logic ep;
        logic lp;
        logic n_lma;
        logic n_lmd;
        logic n_ce;
        logic n_lr;
        logic n_li;
        logic n_ei;
        logic n_la;
        logic ea;
        logic sub;
        logic eu;
        logic n_lb;
        logic n_lo;
    } ctrl_word_t;

    // instruction view of a memory byte
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] operand;
    } instr_t;

    // a memory byte is either an instruction or plain data
    typedef union packed {
        instr_t     instr;
        logic [7:0] raw;
    } mem_word_t;

    // nothing driven, nothing loaded
    localparam ctrl_word_t CTRL_IDLE = '{
        cp: 1'b0, ep: 1'b0, lp: 1'b0,
        n_lma: 1'b1, n_lmd: 1'b1, n_ce: 1'b1, n_lr: 1'b1,
        n_li: 1'b1, n_ei: 1'b1, n_la: 1'b1,
        ea: 1'b0, sub: 1'b0, eu: 1'b0,
        n_lb: 1'b1, n_lo: 1'b1
    };

endpackage

`default_nettype wire

//--- cpu_top.sv
// shuttle pin wrapper; uio_in[7] or ena low holds the cpu, uio_in[4] writes while loading
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
    parameter int RAM_BYTES = 16
) (
    input  logic [7:0] ui_in,
    input  logic [7:0] uio_in,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n,
    output logic [7:0] uo_out,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe
);
    import cpu_pkg::*;

    ctrl_word_t ctrl;
    mem_word_t  mem_out;
    opcode_t    opcode;
    logic [7:0] bus;
    logic [7:0] alu_out;
    logic [7:0] reg_a;
    logic [7:0] reg_b;
    logic [7:0] mar_data;
    logic [3:0] mar_addr;
    logic [3:0] pc_val;
    logic       hold;
    logic       prog_we;
    logic       ram_we_n;
    logic       cf;
    logic       zf;
    logic       halted;

    // unpowered tile behaves as load mode
    assign hold = uio_in[7] | !ena;

    // pin write during load, n_lr strobe during sta
    assign prog_we  = uio_in[7] & uio_in[4];
    assign ram_we_n = ctrl.n_lr & !prog_we;

    program_counter u_pc (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .hold   (hold),
        .bus    (bus),
        .pc_val (pc_val)
    );

    control_sequencer u_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (hold),
        .opcode (opcode),
        .cf     (cf),
        .zf     (zf),
        .ctrl   (ctrl),
        .halted (halted)
    );

    alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold    (hold),
        .ctrl    (ctrl),
        .reg_a   (reg_a),
        .reg_b   (reg_b),
        .alu_out (alu_out),
        .cf      (cf),
        .zf      (zf)
    );

    datapath_registers u_dp (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .pc_val  (pc_val),
        .mem_out (mem_out),
        .alu_out (alu_out),
        .bus     (bus),
        .reg_a   (reg_a),
        .reg_b   (reg_b),
        .opcode  (opcode),
        .out_val (uo_out)
    );

    input_mar_register #(
        .RAM_BYTES (RAM_BYTES)
    ) u_mar (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (hold),
        .prog_addr (uio_in[3:0]),
        .prog_data (ui_in),
        .ctrl      (ctrl),
        .bus       (bus),
        .addr      (mar_addr),
        .data      (mar_data)
    );

    dff_mem #(
        .RAM_BYTES (RAM_BYTES)
    ) u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (mar_addr),
        .data_in  (mar_data),
        .we_n     (ram_we_n),
        .data_out (mem_out)
    );

    // status on uio[2:0], upper uio pins stay inputs
    assign uio_out = {5'd0, zf, cf, halted};
    assign uio_oe  = 8'b0000_0111;

endmodule

`default_nettype wire

//--- datapath_registers.sv
// a, b, ir and output registers around a one-hot bus; an idle bus reads as zero
`timescale 1ns/10ps
`default_nettype none

module datapath_registers (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  logic [3:0]          pc_val,
    input  cpu_pkg::mem_word_t  mem_out,
    input  logic [7:0]          alu_out,
    output logic [7:0]          bus,
    output logic [7:0]          reg_a,
    output logic [7:0]          reg_b,
    output cpu_pkg::opcode_t    opcode,
    output logic [7:0]          out_val
);
    import cpu_pkg::*;

    mem_word_t  ir;
    logic [4:0] src_en;

    // source enables, pc / mem / ir / a / alu
    assign src_en = {ctrl.ep, !ctrl.n_ce, !ctrl.n_ei, ctrl.ea, ctrl.eu};

    // and-or mux
    assign bus = ({8{src_en[4]}} & {4'd0, pc_val})
               | ({8{src_en[3]}} & mem_out.raw)
               | ({8{src_en[2]}} & {4'd0, ir.instr.operand})
               | ({8{src_en[1]}} & reg_a)
               | ({8{src_en[0]}} & alu_out);

    // instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir.raw <= 8'd0;
        end else if (!ctrl.n_li) begin
            ir.raw <= bus;
        end
    end

    assign opcode = ir.instr.opcode;

    // output register, drives uo_out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_val <= 8'd0;
        end else if (!ctrl.n_lo) begin
            out_val <= bus;
        end
    end

    // accumulator
    always_ff @(posedge clk) begin
        if (!ctrl.n_la) begin
            reg_a <= bus;
        end
    end

    // b, second alu operand only
    always_ff @(posedge clk) begin
        if (!ctrl.n_lb) begin
            reg_b <= bus;
        end
    end

    // mux sees at most one enable
    a_bus_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(src_en));

endmodule

`default_nettype wire

//--- dff_mem.sv
// flip-flop ram cleared by reset; write on we_n low at the edge, read is combinational
`timescale 1ns/10ps
`default_nettype none

module dff_mem #(
    parameter int RAM_BYTES = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [3:0]         addr,
    input  logic [7:0]         data_in,
    input  logic               we_n,
    output cpu_pkg::mem_word_t data_out
);
    import cpu_pkg::*;

    mem_word_t mem [RAM_BYTES];

    // storage array
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // every byte reads as LDA 0 after reset
            for (int i = 0; i < RAM_BYTES; i++) begin
                mem[i] <= '0;
            end
        end else if (!we_n) begin
            mem[addr] <= data_in;
        end
    end

    // async read, the bus mux decides who sees it
    assign data_out = mem[addr];

endmodule

`default_nettype wire

//--- input_mar_register.sv
// mar address and write data; pins pass straight through while hold is high
`timescale 1ns/10ps
`default_nettype none

module input_mar_register #(
    parameter int RAM_BYTES = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hold,
    input  logic [3:0]          prog_addr,
    input  logic [7:0]          prog_data,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  logic [7:0]          bus,
    output logic [3:0]          addr,
    output logic [7:0]          data
);
    import cpu_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        data_q;

    // a larger ram would need a wider address
    if (RAM_BYTES > (1 << ADDR_W)) begin : g_size_check
        $error("RAM_BYTES exceeds the 4-bit address range");
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (!ctrl.n_lma) begin
            addr_q <= bus[ADDR_W-1:0];
        end
    end

    // sta data, loaded in T4
    always_ff @(posedge clk) begin
        if (!ctrl.n_lmd) begin
            data_q <= bus;
        end
    end

    // load mode bypass
    assign addr = hold ? prog_addr : addr_q;
    assign data = hold ? prog_data : data_q;

endmodule

`default_nettype wire

//--- program_counter.sv
// 4-bit program counter; wraps at 16, load wins over increment, cleared while hold is high
`timescale 1ns/10ps
`default_nettype none

module program_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  logic                hold,
    input  logic [7:0]          bus,
    output logic [3:0]          pc_val
);
    import cpu_pkg::*;

    logic [ADDR_W-1:0] pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (hold) begin
            // program load, restart from address 0
            pc_q <= '0;
        end else if (ctrl.lp) begin
            // jump target comes from the ir operand
            pc_q <= bus[ADDR_W-1:0];
        end else if (ctrl.cp) begin
            // natural wrap modulo 16
            pc_q <= pc_q + 1'b1;
        end
    end

    assign pc_val = pc_q;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cpu -o tb_cpu_sim
./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log
if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb_checker.sv
// checks one program at a time, at most 8 outputs each; a repeated output value cannot be seen
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [7:0]      uio_in,
    input  logic [7:0]      uo_out,
    input  logic [7:0]      uio_out,
    input  logic [7:0]      uio_oe,
    input  logic [0:7][7:0] exp_outs,
    input  logic [3:0]      exp_n,
    input  logic            exp_cf,
    input  logic            exp_zf,
    input  logic [7:0]      exp_instr,
    output int              mismatches,
    output int              faults
);
    logic       load;
    logic       halted;
    logic [7:0] prev_out;
    logic       prev_load;
    logic       prev_halted;
    int         out_idx;
    int         run_cyc;
    int         halt_cyc;

    assign load   = uio_in[7];
    assign halted = uio_out[0];

    initial begin
        mismatches  = 0;
        faults      = 0;
        out_idx     = 0;
        run_cyc     = 0;
        halt_cyc    = 0;
        prev_out    = 8'h00;
        prev_load   = 1'b1;
        prev_halted = 1'b0;
    end

    // pins sampled on the edge, so these are the values of the cycle just ended
    always @(posedge clk) begin
        if (!rst_n || load) begin
            out_idx = 0;
            run_cyc = 0;
        end else begin
            // first run cycle, reset or load mode must have cleared the status
            if (prev_load && uio_out[2:0] != 3'b000) begin
                faults++;
                $display("error at %0t: halted or flags not clear at start of run", $time);
            end
            // each new output value is the next OUT of the program
            if (uo_out != prev_out) begin
                if (prev_halted) begin
                    faults++;
                    $display("error at %0t: uo_out changed after halt", $time);
                end else if (out_idx >= int'(exp_n)) begin
                    faults++;
                    $display("error at %0t: unexpected extra output %02h", $time, uo_out);
                end else begin
                    if (uo_out != exp_outs[out_idx]) begin
                        mismatches++;
                        $display("mismatch at %0t: output %0d is %02h, expected %02h",
                                 $time, out_idx, uo_out, exp_outs[out_idx]);
                    end
                    out_idx++;
                end
            end
            if (prev_halted && !halted) begin
                faults++;
                $display("error at %0t: halted dropped while still in run mode", $time);
            end
            // hlt is the last instruction, it stops at the end of its T3
            if (halted && !prev_halted) begin
                halt_cyc = 6 * (int'(exp_instr) - 1) + 4;
                if (uio_out[1] != exp_cf) begin
                    mismatches++;
                    $display("mismatch at %0t: cf is %b, expected %b", $time, uio_out[1], exp_cf);
                end
                if (uio_out[2] != exp_zf) begin
                    mismatches++;
                    $display("mismatch at %0t: zf is %b, expected %b", $time, uio_out[2], exp_zf);
                end
                // status pins 0 to 2 are the only outputs
                if (uio_oe != 8'b0000_0111) begin
                    mismatches++;
                    $display("mismatch at %0t: uio_oe is %02h, expected 07", $time, uio_oe);
                end
                if (run_cyc != halt_cyc) begin
                    mismatches++;
                    $display("mismatch at %0t: halted after %0d run cycles, expected %0d",
                             $time, run_cyc, halt_cyc);
                end
                if (out_idx != int'(exp_n)) begin
                    faults++;
                    $display("error at %0t: missing output, got %0d of %0d values",
                             $time, out_idx, exp_n);
                end
            end
            run_cyc++;
        end
        prev_out    = uo_out;
        prev_load   = load || !rst_n;
        prev_halted = halted;
    end

endmodule

`default_nettype wire

//--- tb_cpu.sv
// four fixed programs loaded through the pins; every program must end in HLT within its budget
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int NUM_PROGS    = 4;
    localparam int RESET_CYCLES = 4;
    localparam int HALT_WAIT    = 16;

    // one program with what it must produce
    typedef struct packed {
        logic             do_reset;
        mem_word_t [0:15] image;
        logic [0:7][7:0]  outs;
        logic [3:0]       n_outs;
        logic             cf;
        logic             zf;
        logic [7:0]       n_instr;
    } prog_t;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;
    prog_t      progs [NUM_PROGS];
    prog_t      cur;
    int         cycles = 0;
    int         limit = 0;
    int         mismatches;
    int         faults;

    cpu_top #(
        .RAM_BYTES (16)
    ) dut_i (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe)
    );

    tb_checker chk_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .uio_in     (uio_in),
        .uo_out     (uo_out),
        .uio_out    (uio_out),
        .uio_oe     (uio_oe),
        .exp_outs   (cur.outs),
        .exp_n      (cur.n_outs),
        .exp_cf     (cur.cf),
        .exp_zf     (cur.zf),
        .exp_instr  (cur.n_instr),
        .mismatches (mismatches),
        .faults     (faults)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fill_table();
        // lda 14, out, lda 15, out, hlt
        progs[0] = '{do_reset: 1'b1,
            image: {8'h0E, 8'hE0, 8'h0F, 8'hE0, 8'hF0, {9{8'h00}}, 8'h5A, 8'hC3},
            outs: {8'h5A, 8'hC3, {6{8'h00}}}, n_outs: 4'd2, cf: 1'b0, zf: 1'b0, n_instr: 8'd5};
        // f0+20 wraps with carry, 10-30 borrows, e0-e0 gives zero without borrow
        // ldi 5 and out after the hlt must never run
        progs[1] = '{do_reset: 1'b0,
            image: {8'h0D, 8'h1E, 8'hE0, 8'h2F, 8'hE0, 8'h2C, 8'hE0, 8'hF0,
                    8'h45, 8'hE0, 8'h00, 8'h00, 8'hE0, 8'hF0, 8'h20, 8'h30},
            outs: {8'h10, 8'hE0, 8'h00, {5{8'h00}}}, n_outs: 4'd3,
            cf: 1'b1, zf: 1'b1, n_instr: 8'd8};
        // sta 14 then lda 14 over the old 11 in that byte
        progs[2] = '{do_reset: 1'b0,
            image: {8'h49, 8'h1F, 8'h3E, 8'h41, 8'hE0, 8'h0E, 8'hE0, 8'hF0,
                    {6{8'h00}}, 8'h11, 8'h77},
            outs: {8'h01, 8'h80, {6{8'h00}}}, n_outs: 4'd2, cf: 1'b0, zf: 1'b0, n_instr: 8'd8};
        // countdown 3..1, then jz taken, jc taken, jc and jz not taken
        progs[3] = '{do_reset: 1'b1,
            image: {8'h43, 8'hE0, 8'h2F, 8'h75, 8'h51, 8'h67, 8'hE0, 8'h2F,
                    8'h6A, 8'hE0, 8'h7C, 8'h47, 8'hE0, 8'hF0, 8'h00, 8'h01},
            outs: {8'h03, 8'h02, 8'h01, 8'hFF, 8'h07, {3{8'h00}}}, n_outs: 4'd5,
            cf: 1'b0, zf: 1'b0, n_instr: 8'd20};
    endtask

    task automatic run_program(input prog_t p);
        if (p.do_reset) begin
            @(posedge clk);
            rst_n  <= 1'b0;
            uio_in <= 8'h80;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
        end
        // load mode with the write strobe, one byte per cycle
        for (int a = 0; a < 16; a++) begin
            @(posedge clk);
            cur    <= p;
            uio_in <= {4'b1001, 4'(a)};
            ui_in  <= p.image[a].raw;
        end
        // the edge after this one is the first run cycle
        @(posedge clk);
        uio_in <= 8'h00;
        ui_in  <= 8'h00;
        // halted read on the falling edge, away from the dut update
        @(negedge clk);
        while (!uio_out[0]) @(negedge clk);
        repeat (HALT_WAIT) @(negedge clk);
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other", mismatches, faults);
    endtask

    // run budget from the instruction counts of the table
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: cpu did not halt within %0d cycles", limit);
            print_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst_n  = 1'b0;
        ena    = 1'b1;
        ui_in  = 8'h00;
        uio_in = 8'h80;
        cur    = '0;
        fill_table();
        limit = 32;
        for (int i = 0; i < NUM_PROGS; i++) begin
            limit += 6 * int'(progs[i].n_instr) + 16 + RESET_CYCLES + HALT_WAIT + 4;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_PROGS; i++) begin
            run_program(progs[i]);
        end
        @(posedge clk);
        print_counts();
        if (mismatches + faults == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
